/* Makefile */
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing
TOP        ?= tb_mmu
FILELIST   ?= compile.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
FAIL_TEXT  := Some tests failed
PASS_TEXT  := All tests passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

sim: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_TEXT)" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_TEXT)" $(LOG); then echo "Simulation gave no result"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* compile.f */
src/mmu_pkg.sv
src/mmu_seg_map.sv
src/mmu_tlb_write.sv
src/mmu_tlb_entry.sv
src/mmu_tlb_lookup.sv
src/mmu_top.sv
tests/tb_mmu.sv

/* src/mmu_pkg.sv */
package mmu_pkg;

    // ------------------------------------------------------------
    // TLB geometry
    // ------------------------------------------------------------
    localparam int tlb_entries_lp  = 16;
    localparam int tlb_index_w_lp  = 4;
    localparam int vpn2_w_lp       = 19;
    localparam int pfn_w_lp        = 24;  // Only low 20 bits reach the bus.
    localparam int offset_w_lp     = 12;
    localparam int tlb_config_w_lp = 75;

    // ------------------------------------------------------------
    // Configuration word layout, low bit positions
    // ------------------------------------------------------------
    // {vpn2, lo1_pfn, lo1_d, lo1_v, lo0_pfn, lo0_d, lo0_v, index}
    localparam int cfg_index_lsb_lp   = 0;
    localparam int cfg_lo0_v_lp       = cfg_index_lsb_lp + tlb_index_w_lp;
    localparam int cfg_lo0_d_lp       = cfg_lo0_v_lp + 1;
    localparam int cfg_lo0_pfn_lsb_lp = cfg_lo0_d_lp + 1;
    localparam int cfg_lo1_v_lp       = cfg_lo0_pfn_lsb_lp + pfn_w_lp;
    localparam int cfg_lo1_d_lp       = cfg_lo1_v_lp + 1;
    localparam int cfg_lo1_pfn_lsb_lp = cfg_lo1_d_lp + 1;
    localparam int cfg_vpn2_lsb_lp    = cfg_lo1_pfn_lsb_lp + pfn_w_lp;

    // ------------------------------------------------------------
    // Segments
    // ------------------------------------------------------------
    localparam logic [2:0]  seg_kseg0_lp   = 3'b100;  // Cached, unmapped.
    localparam logic [2:0]  seg_kseg1_lp   = 3'b101;  // Uncached, unmapped.
    localparam logic [28:0] direct_mask_lp = 29'h1fff_ffff;

    // One virtual address word, seen by segment or by page.
    typedef union packed {
        struct packed {
            logic [2:0]  seg;
            logic [28:0] rest;
        } seg;
        struct packed {
            logic [vpn2_w_lp-1:0]   vpn2;
            logic                   odd;
            logic [offset_w_lp-1:0] offset;
        } page;
    } vaddr_u;

endpackage

/* src/mmu_seg_map.sv */
`timescale 1ns/1ns

module mmu_seg_map (
    input  logic [31:0] addr_i,
    input  logic        en_i,
    input  logic        user_mode_i,
    output logic [31:0] addr_o,
    output logic        mapped_o,
    output logic        invalid_o
);

    import mmu_pkg::*;

    vaddr_u va;
    logic   is_kseg0;
    logic   is_kseg1;
    logic   is_kernel;

    assign va = addr_i;

    // ------------------------------------------------------------
    // Segment decode
    // ------------------------------------------------------------
    assign is_kseg0  = (va.seg.seg == seg_kseg0_lp);
    assign is_kseg1  = (va.seg.seg == seg_kseg1_lp);
    assign is_kernel = va.seg.seg[2];  // Upper half of the space.

    // kuseg and kseg2/3 go through the TLB.
    assign mapped_o = !(is_kseg0 || is_kseg1);

    // Unmapped segments fold onto the low 512 MB.
    always_comb begin
        if (mapped_o) begin
            addr_o = addr_i;
        end else begin
            addr_o = addr_i & {3'b000, direct_mask_lp};
        end
    end

    assign invalid_o = en_i && user_mode_i && is_kernel;

endmodule

/* src/mmu_tlb_entry.sv */
`timescale 1ns/1ns

module mmu_tlb_entry (
    input  logic                          clk,
    input  logic                          rst_i,
    input  logic                          we_i,
    input  logic [mmu_pkg::vpn2_w_lp-1:0] vpn2_i,
    input  logic [mmu_pkg::pfn_w_lp-1:0]  pfn0_i,
    input  logic [mmu_pkg::pfn_w_lp-1:0]  pfn1_i,
    input  logic                          d0_i,
    input  logic                          v0_i,
    input  logic                          d1_i,
    input  logic                          v1_i,
    input  logic [mmu_pkg::vpn2_w_lp-1:0] inst_vpn2_i,
    input  logic                          inst_odd_i,
    input  logic [mmu_pkg::vpn2_w_lp-1:0] data_vpn2_i,
    input  logic                          data_odd_i,
    output logic                          inst_match_o,
    output logic [mmu_pkg::pfn_w_lp-1:0]  inst_pfn_o,
    output logic                          inst_v_o,
    output logic                          inst_d_o,
    output logic                          data_match_o,
    output logic [mmu_pkg::pfn_w_lp-1:0]  data_pfn_o,
    output logic                          data_v_o,
    output logic                          data_d_o
);

    import mmu_pkg::*;

    logic                 occupied_q;
    logic [vpn2_w_lp-1:0] vpn2_q;
    logic [pfn_w_lp-1:0]  pfn0_q;
    logic [pfn_w_lp-1:0]  pfn1_q;
    logic                 d0_q;
    logic                 v0_q;
    logic                 d1_q;
    logic                 v1_q;

    // ------------------------------------------------------------
    // Page pair storage
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst_i) begin
            occupied_q <= 1'b0;
            vpn2_q     <= '0;
            pfn0_q     <= '0;
            pfn1_q     <= '0;
            d0_q       <= 1'b0;
            v0_q       <= 1'b0;
            d1_q       <= 1'b0;
            v1_q       <= 1'b0;
        end else if (we_i) begin
            occupied_q <= 1'b1;
            vpn2_q     <= vpn2_i;
            pfn0_q     <= pfn0_i;
            pfn1_q     <= pfn1_i;
            d0_q       <= d0_i;
            v0_q       <= v0_i;
            d1_q       <= d1_i;
            v1_q       <= v1_i;
        end
    end

    // ------------------------------------------------------------
    // Compare and half select, one set per port
    // ------------------------------------------------------------
    assign inst_match_o = occupied_q && (vpn2_q == inst_vpn2_i);
    assign inst_pfn_o   = inst_odd_i ? pfn1_q : pfn0_q;
    assign inst_v_o     = inst_odd_i ? v1_q : v0_q;
    assign inst_d_o     = inst_odd_i ? d1_q : d0_q;

    assign data_match_o = occupied_q && (vpn2_q == data_vpn2_i);
    assign data_pfn_o   = data_odd_i ? pfn1_q : pfn0_q;
    assign data_v_o     = data_odd_i ? v1_q : v0_q;
    assign data_d_o     = data_odd_i ? d1_q : d0_q;

endmodule

/* src/mmu_tlb_lookup.sv */
`timescale 1ns/1ns

module mmu_tlb_lookup (
    input  logic                                                     clk,
    input  logic                                                     rst_i,
    input  logic [mmu_pkg::tlb_entries_lp-1:0]                       match_i,
    input  logic [mmu_pkg::tlb_entries_lp-1:0][mmu_pkg::pfn_w_lp-1:0] pfn_i,
    input  logic [mmu_pkg::tlb_entries_lp-1:0]                       v_i,
    input  logic [mmu_pkg::tlb_entries_lp-1:0]                       d_i,
    output logic                                                     hit_o,
    output logic [mmu_pkg::pfn_w_lp-1:0]                             pfn_o,
    output logic                                                     v_o,
    output logic                                                     d_o
);

    import mmu_pkg::*;

    assign hit_o = |match_i;

    // ------------------------------------------------------------
    // AND-OR select of the matching entry
    // ------------------------------------------------------------
    always_comb begin
        pfn_o = '0;
        v_o   = 1'b0;
        d_o   = 1'b0;
        for (int i = 0; i < tlb_entries_lp; i++) begin
            pfn_o = pfn_o | (pfn_i[i] & {pfn_w_lp{match_i[i]}});
            v_o   = v_o | (v_i[i] & match_i[i]);
            d_o   = d_o | (d_i[i] & match_i[i]);
        end
    end

    // Software keeps vpn2 values unique across the array.
    assert property (@(posedge clk) disable iff (rst_i) $onehot0(match_i))
        else $error("mmu_tlb_lookup: multiple TLB entries hit");

endmodule

/* src/mmu_tlb_write.sv */
`timescale 1ns/1ns

module mmu_tlb_write (
    input  logic                                 clk,
    input  logic                                 rst_i,
    input  logic                                 tlbwi_i,
    input  logic [mmu_pkg::tlb_config_w_lp-1:0]  config_i,
    output logic [mmu_pkg::tlb_entries_lp-1:0]   we_o,
    output logic [mmu_pkg::vpn2_w_lp-1:0]        vpn2_o,
    output logic [mmu_pkg::pfn_w_lp-1:0]         pfn0_o,
    output logic [mmu_pkg::pfn_w_lp-1:0]         pfn1_o,
    output logic                                 d0_o,
    output logic                                 v0_o,
    output logic                                 d1_o,
    output logic                                 v1_o
);

    import mmu_pkg::*;

    logic [tlb_index_w_lp-1:0] index;

    // ------------------------------------------------------------
    // Field unpack
    // ------------------------------------------------------------
    assign index  = config_i[cfg_index_lsb_lp +: tlb_index_w_lp];
    assign v0_o   = config_i[cfg_lo0_v_lp];
    assign d0_o   = config_i[cfg_lo0_d_lp];
    assign pfn0_o = config_i[cfg_lo0_pfn_lsb_lp +: pfn_w_lp];
    assign v1_o   = config_i[cfg_lo1_v_lp];
    assign d1_o   = config_i[cfg_lo1_d_lp];
    assign pfn1_o = config_i[cfg_lo1_pfn_lsb_lp +: pfn_w_lp];
    assign vpn2_o = config_i[cfg_vpn2_lsb_lp +: vpn2_w_lp];

    // ------------------------------------------------------------
    // Index decode
    // ------------------------------------------------------------
    always_comb begin
        we_o = '0;
        if (tlbwi_i) begin
            we_o[index] = 1'b1;  // Exactly one entry per strobe.
        end
    end

    // A strobe writes one entry, and no entry is written without it.
    assert property (@(posedge clk) disable iff (rst_i)
        tlbwi_i ? $onehot(we_o) : (we_o == '0))
        else $error("mmu_tlb_write: write enable not one-hot or zero");

endmodule

/* src/mmu_top.sv */
`timescale 1ns/1ns

module mmu_top (
    input  logic                                clk,
    input  logic                                rst_i,
    input  logic [31:0]                         inst_addr_i,
    input  logic                                inst_en_i,
    input  logic [31:0]                         data_addr_i,
    input  logic                                data_en_i,
    input  logic                                data_we_i,
    input  logic                                user_mode_i,
    input  logic [mmu_pkg::tlb_config_w_lp-1:0] tlb_config_i,
    input  logic                                tlbwi_i,
    output logic [31:0]                         inst_addr_o,
    output logic [31:0]                         data_addr_o,
    output logic                                inst_exp_o,
    output logic                                data_exp_o
);

    import mmu_pkg::*;

    vaddr_u inst_va;
    vaddr_u data_va;

    logic [31:0] inst_direct;
    logic [31:0] data_direct;
    logic        inst_mapped;
    logic        data_mapped;
    logic        inst_invalid;
    logic        data_invalid;

    logic [tlb_entries_lp-1:0] entry_we;
    logic [vpn2_w_lp-1:0]      wr_vpn2;
    logic [pfn_w_lp-1:0]       wr_pfn0;
    logic [pfn_w_lp-1:0]       wr_pfn1;
    logic                      wr_d0;
    logic                      wr_v0;
    logic                      wr_d1;
    logic                      wr_v1;

    logic [tlb_entries_lp-1:0]               inst_match;
    logic [tlb_entries_lp-1:0][pfn_w_lp-1:0] inst_pfn_arr;
    logic [tlb_entries_lp-1:0]               inst_v_arr;
    logic [tlb_entries_lp-1:0]               inst_d_arr;
    logic [tlb_entries_lp-1:0]               data_match;
    logic [tlb_entries_lp-1:0][pfn_w_lp-1:0] data_pfn_arr;
    logic [tlb_entries_lp-1:0]               data_v_arr;
    logic [tlb_entries_lp-1:0]               data_d_arr;

    logic                inst_hit;
    logic                data_hit;
    logic [pfn_w_lp-1:0] inst_pfn;
    logic [pfn_w_lp-1:0] data_pfn;
    logic                inst_v;
    logic                data_v;
    logic                data_d;

    assign inst_va = inst_addr_i;
    assign data_va = data_addr_i;

    // ------------------------------------------------------------
    // Segment classification
    // ------------------------------------------------------------
    mmu_seg_map u_seg_inst (
        .addr_i      (inst_addr_i),
        .en_i        (inst_en_i),
        .user_mode_i (user_mode_i),
        .addr_o      (inst_direct),
        .mapped_o    (inst_mapped),
        .invalid_o   (inst_invalid)
    );

    mmu_seg_map u_seg_data (
        .addr_i      (data_addr_i),
        .en_i        (data_en_i),
        .user_mode_i (user_mode_i),
        .addr_o      (data_direct),
        .mapped_o    (data_mapped),
        .invalid_o   (data_invalid)
    );

    // ------------------------------------------------------------
    // TLB write path and entry array
    // ------------------------------------------------------------
    mmu_tlb_write u_tlb_write (
        .clk      (clk),
        .rst_i    (rst_i),
        .tlbwi_i  (tlbwi_i),
        .config_i (tlb_config_i),
        .we_o     (entry_we),
        .vpn2_o   (wr_vpn2),
        .pfn0_o   (wr_pfn0),
        .pfn1_o   (wr_pfn1),
        .d0_o     (wr_d0),
        .v0_o     (wr_v0),
        .d1_o     (wr_d1),
        .v1_o     (wr_v1)
    );

    for (genvar i = 0; i < tlb_entries_lp; i++) begin : g_entry
        mmu_tlb_entry u_entry (
            .clk          (clk),
            .rst_i        (rst_i),
            .we_i         (entry_we[i]),
            .vpn2_i       (wr_vpn2),
            .pfn0_i       (wr_pfn0),
            .pfn1_i       (wr_pfn1),
            .d0_i         (wr_d0),
            .v0_i         (wr_v0),
            .d1_i         (wr_d1),
            .v1_i         (wr_v1),
            .inst_vpn2_i  (inst_va.page.vpn2),
            .inst_odd_i   (inst_va.page.odd),
            .data_vpn2_i  (data_va.page.vpn2),
            .data_odd_i   (data_va.page.odd),
            .inst_match_o (inst_match[i]),
            .inst_pfn_o   (inst_pfn_arr[i]),
            .inst_v_o     (inst_v_arr[i]),
            .inst_d_o     (inst_d_arr[i]),
            .data_match_o (data_match[i]),
            .data_pfn_o   (data_pfn_arr[i]),
            .data_v_o     (data_v_arr[i]),
            .data_d_o     (data_d_arr[i])
        );
    end

    // ------------------------------------------------------------
    // Per-port lookup
    // ------------------------------------------------------------
    mmu_tlb_lookup u_lookup_inst (
        .clk     (clk),
        .rst_i   (rst_i),
        .match_i (inst_match),
        .pfn_i   (inst_pfn_arr),
        .v_i     (inst_v_arr),
        .d_i     (inst_d_arr),
        .hit_o   (inst_hit),
        .pfn_o   (inst_pfn),
        .v_o     (inst_v),
        .d_o     ()
    );

    mmu_tlb_lookup u_lookup_data (
        .clk     (clk),
        .rst_i   (rst_i),
        .match_i (data_match),
        .pfn_i   (data_pfn_arr),
        .v_i     (data_v_arr),
        .d_i     (data_d_arr),
        .hit_o   (data_hit),
        .pfn_o   (data_pfn),
        .v_o     (data_v),
        .d_o     (data_d)
    );

    // ------------------------------------------------------------
    // Final address and exception
    // ------------------------------------------------------------
    assign inst_addr_o = (inst_mapped && inst_hit)
                       ? {inst_pfn[31-offset_w_lp:0], inst_va.page.offset}
                       : inst_direct;  // Miss passes the input through.
    assign data_addr_o = (data_mapped && data_hit)
                       ? {data_pfn[31-offset_w_lp:0], data_va.page.offset}
                       : data_direct;

    assign inst_exp_o = inst_en_i && (inst_invalid
                      || (inst_mapped && !inst_hit)
                      || (inst_mapped && inst_hit && !inst_v));

    // Stores also need a dirty page.
    assign data_exp_o = data_en_i && (data_invalid
                      || (data_mapped && !data_hit)
                      || (data_mapped && data_hit && !data_v)
                      || (data_mapped && data_hit && data_we_i && !data_d));

endmodule

/* tests/tb_mmu.sv */
`timescale 1ns/1ns

module tb_mmu;

    import mmu_pkg::*;

    localparam int clk_period_lp = 8;
    localparam int max_cycles_lp = 2500;  // About 600 cycles of tests, with margin.

    logic                       clk;
    logic                       rst;
    logic [31:0]                inst_addr;
    logic                       inst_en;
    logic [31:0]                data_addr;
    logic                       data_en;
    logic                       data_we;
    logic                       user_mode;
    logic [tlb_config_w_lp-1:0] tlb_config;
    logic                       tlbwi;
    logic [31:0]                inst_addr_o;
    logic [31:0]                data_addr_o;
    logic                       inst_exp_o;
    logic                       data_exp_o;

    // Shadow copy of the TLB.
    logic        sh_occ  [16];
    logic [18:0] sh_vpn2 [16];
    logic [23:0] sh_pfn0 [16];
    logic [23:0] sh_pfn1 [16];
    logic        sh_d0   [16];
    logic        sh_v0   [16];
    logic        sh_d1   [16];
    logic        sh_v1   [16];

    logic [31:0] rng_state;
    int          errors;
    int          checks;

    mmu_top u_mmu_top (
        .clk          (clk),
        .rst_i        (rst),
        .inst_addr_i  (inst_addr),
        .inst_en_i    (inst_en),
        .data_addr_i  (data_addr),
        .data_en_i    (data_en),
        .data_we_i    (data_we),
        .user_mode_i  (user_mode),
        .tlb_config_i (tlb_config),
        .tlbwi_i      (tlbwi),
        .inst_addr_o  (inst_addr_o),
        .data_addr_o  (data_addr_o),
        .inst_exp_o   (inst_exp_o),
        .data_exp_o   (data_exp_o)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period_lp / 2) clk = ~clk;
    end

    initial begin
        #(max_cycles_lp * clk_period_lp);
        $display("Timeout: the run did not finish within %0d cycles", max_cycles_lp);
        $display("Some tests failed");
        $finish;
    end

    // ------------------------------------------------------------
    // Reference model and helpers
    // ------------------------------------------------------------
    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // Returns {exception, physical address}.
    function automatic logic [32:0] predict(input logic [31:0] addr, input logic en,
                                            input logic store, input logic um);
        logic        mapped;
        logic        hit;
        logic [23:0] pfn;
        logic        v;
        logic        d;
        logic [31:0] pa;
        logic        exc;
        mapped = !(addr[31:29] == 3'b100 || addr[31:29] == 3'b101);
        hit = 1'b0;
        pfn = '0;
        v   = 1'b0;
        d   = 1'b0;
        for (int i = 0; i < 16; i++) begin
            if (sh_occ[i] && sh_vpn2[i] == addr[31:13]) begin
                hit = 1'b1;
                pfn = addr[12] ? sh_pfn1[i] : sh_pfn0[i];
                v   = addr[12] ? sh_v1[i] : sh_v0[i];
                d   = addr[12] ? sh_d1[i] : sh_d0[i];
            end
        end
        if (!mapped) begin
            pa = {3'b000, addr[28:0]};
        end else if (hit) begin
            pa = {pfn[19:0], addr[11:0]};
        end else begin
            pa = addr;  // A miss passes through.
        end
        exc = en && ((um && addr[31]) || (mapped && !hit) || (mapped && hit && !v)
                     || (mapped && hit && store && !d));
        return {exc, pa};
    endfunction

    function automatic logic vpn2_taken(input logic [18:0] vpn2, input int idx);
        for (int i = 0; i < 16; i++) begin
            if (i != idx && sh_occ[i] && sh_vpn2[i] == vpn2) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic check_ports(input string name);
        logic [32:0] exp_i;
        logic [32:0] exp_d;
        exp_i = predict(inst_addr, inst_en, 1'b0, user_mode);
        exp_d = predict(data_addr, data_en, data_we, user_mode);
        checks++;
        if (inst_addr_o !== exp_i[31:0]) begin
            errors++;
            $display("Fail %s inst addr: expected %h, actual %h", name, exp_i[31:0], inst_addr_o);
        end
        if (inst_exp_o !== exp_i[32]) begin
            errors++;
            $display("Fail %s inst exc: expected %b, actual %b", name, exp_i[32], inst_exp_o);
        end
        if (data_addr_o !== exp_d[31:0]) begin
            errors++;
            $display("Fail %s data addr: expected %h, actual %h", name, exp_d[31:0], data_addr_o);
        end
        if (data_exp_o !== exp_d[32]) begin
            errors++;
            $display("Fail %s data exc: expected %b, actual %b", name, exp_d[32], data_exp_o);
        end
    endtask

    task automatic access(input string name, input logic [31:0] ia, input logic [31:0] da,
                          input logic ie, input logic de, input logic we, input logic um);
        @(posedge clk);
        inst_addr <= ia;
        data_addr <= da;
        inst_en   <= ie;
        data_en   <= de;
        data_we   <= we;
        user_mode <= um;
        @(negedge clk);  // Outputs settled.
        check_ports(name);
    endtask

    task automatic tlb_write(input logic [3:0] idx, input logic [18:0] vpn2,
                             input logic [23:0] pfn0, input logic d0, input logic v0,
                             input logic [23:0] pfn1, input logic d1, input logic v1);
        @(posedge clk);
        tlb_config <= {vpn2, pfn1, d1, v1, pfn0, d0, v0, idx};
        tlbwi      <= 1'b1;
        @(posedge clk);
        tlbwi      <= 1'b0;
        sh_occ[idx]  = 1'b1;
        sh_vpn2[idx] = vpn2;
        sh_pfn0[idx] = pfn0;
        sh_pfn1[idx] = pfn1;
        sh_d0[idx]   = d0;
        sh_v0[idx]   = v0;
        sh_d1[idx]   = d1;
        sh_v1[idx]   = v1;
    endtask

    // ------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------
    task automatic unmapped_segments();
        access("unmapped_segments", 32'h8000_1234, 32'ha012_3458, 1'b1, 1'b1, 1'b0, 1'b0);
        access("unmapped_segments", 32'hbfff_fffc, 32'h9f00_0010, 1'b1, 1'b1, 1'b1, 1'b0);
    endtask

    task automatic user_violation();
        access("user_violation", 32'h8000_0000, 32'hc000_1000, 1'b1, 1'b1, 1'b0, 1'b1);
        access("user_violation", 32'h8000_0000, 32'hc000_1000, 1'b0, 1'b0, 1'b0, 1'b1);
    endtask

    task automatic miss_after_reset();
        access("miss_after_reset", 32'h0040_0000, 32'hc000_2000, 1'b1, 1'b1, 1'b0, 1'b0);
        access("miss_after_reset", 32'he000_0abc, 32'h0000_1004, 1'b1, 1'b1, 1'b1, 1'b0);
    endtask

    task automatic write_and_hit();
        tlb_write(4'd3, 19'h00200, 24'h012345, 1'b1, 1'b1, 24'h0abcde, 1'b1, 1'b1);
        tlb_write(4'd9, 19'h60000, 24'h000777, 1'b1, 1'b1, 24'h000888, 1'b1, 1'b1);
        access("write_and_hit", 32'h0040_0123, 32'h0040_1abc, 1'b1, 1'b1, 1'b1, 1'b0);
        access("write_and_hit", 32'h0040_1ffc, 32'h0040_0004, 1'b1, 1'b1, 1'b0, 1'b0);
        access("write_and_hit", 32'hc000_0010, 32'hc000_1020, 1'b1, 1'b1, 1'b1, 1'b0);
        tlb_write(4'd3, 19'h00300, 24'h055555, 1'b1, 1'b1, 24'h066666, 1'b1, 1'b1);
        access("write_and_hit", 32'h0040_0123, 32'h0060_1abc, 1'b1, 1'b1, 1'b0, 1'b0);
    endtask

    task automatic valid_dirty();
        tlb_write(4'd5, 19'h00500, 24'h0a0a0a, 1'b1, 1'b0, 24'h0b0b0b, 1'b0, 1'b1);
        access("valid_dirty", 32'h00a0_0040, 32'h00a0_0040, 1'b1, 1'b1, 1'b0, 1'b0);
        access("valid_dirty", 32'h00a0_1040, 32'h00a0_1040, 1'b1, 1'b1, 1'b0, 1'b0);
        access("valid_dirty", 32'h00a0_1040, 32'h00a0_1040, 1'b1, 1'b1, 1'b1, 1'b0);
    endtask

    task automatic random_sweep();
        logic [31:0] r;
        logic [31:0] ia;
        logic [31:0] da;
        logic [31:0] raw;
        logic [18:0] vpn2;
        logic [23:0] pfn0;
        logic [23:0] pfn1;
        for (int n = 0; n < 200; n++) begin
            r = next_random();
            if (r[1:0] == 2'd0) begin
                raw  = next_random();
                vpn2 = raw[31:13];
                while (vpn2_taken(vpn2, int'(r[7:4]))) begin
                    raw  = next_random();
                    vpn2 = raw[31:13];  // Keep every vpn2 unique.
                end
                raw  = next_random();
                pfn0 = raw[31:8];
                raw  = next_random();
                pfn1 = raw[31:8];
                tlb_write(r[7:4], vpn2, pfn0, r[8], r[9], pfn1, r[10], r[11]);
            end
            ia = next_random();
            da = next_random();
            if (r[12] && sh_occ[r[19:16]]) begin
                ia = {sh_vpn2[r[19:16]], ia[12:0]};
            end
            if (r[13] && sh_occ[r[23:20]]) begin
                da = {sh_vpn2[r[23:20]], da[12:0]};
            end
            access("random_sweep", ia, da, r[14] | r[24], r[15] | r[25], r[26],
                   r[31:28] == 4'd0);
        end
    endtask

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------
    initial begin
        rst        = 1'b1;
        inst_addr  = '0;
        inst_en    = 1'b0;
        data_addr  = '0;
        data_en    = 1'b0;
        data_we    = 1'b0;
        user_mode  = 1'b0;
        tlb_config = '0;
        tlbwi      = 1'b0;
        rng_state  = 32'd72148;
        errors     = 0;
        checks     = 0;
        for (int i = 0; i < 16; i++) begin
            sh_occ[i] = 1'b0;  // Reset leaves every entry empty.
        end
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        unmapped_segments();
        user_violation();
        miss_after_reset();
        write_and_hit();
        valid_dirty();
        random_sweep();

        @(posedge clk);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule
